/* design/sync_pkg.sv */
`default_nettype none

package sync_pkg;

  typedef logic [63:0] ns_time_t;          // Software time in ns.
  typedef logic [63:0] tick_time_t;        // System time in clock ticks.
  typedef logic [63:0] lap_t;              // Whole sync periods.
  typedef logic signed [64:0] time_diff_t;
  typedef logic [17:0] period_cnt_t;

  localparam logic [31:0] SYNC_PERIOD_NS = 32'd500000;
  localparam logic [17:0] SYNC_PERIOD_TICKS = 18'd10240;  // 20.48 MHz over one period.

  // Phase at which the predictor moves on to the next sync.
  localparam logic [17:0] PREDICT_OFFSET = SYNC_PERIOD_TICKS >> 1;

  typedef enum logic [1:0] {
    SLEW_IDLE,
    SLEW_WAIT_DIFF,
    SLEW_ACTIVE
  } slew_state_t;

endpackage

`default_nettype wire

/* design/sync_input.sv */
`default_nettype none

module sync_input (
  input  wire                   CLK,
  input  wire                   arst_n,
  input  wire                   ext_sync,
  input  wire sync_pkg::ns_time_t set_time,
  input  wire                   set_update,
  input  wire                   aligned_valid,
  output logic                  sync_pulse,
  output sync_pkg::ns_time_t    captured_time,
  output logic                  capture_strobe,
  output logic                  load_pending
);

  logic [2:0] sync_hist;  // [1:0] synchronizer, [2] previous level.
  logic       edge_seen;

  assign edge_seen = (sync_hist == 3'b011);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sync_hist  <= 3'b000;
      sync_pulse <= 1'b0;
    end else begin
      sync_hist  <= {sync_hist[1:0], ext_sync};
      sync_pulse <= edge_seen;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      capture_strobe <= 1'b0;
    end else begin
      capture_strobe <= set_update;
    end
  end

  always_ff @(posedge CLK) begin
    if (set_update) begin
      captured_time <= set_time;
    end
  end

  // Armed once the divider has restarted, so a stale result is never taken.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      load_pending <= 1'b0;
    end else if (capture_strobe) begin
      load_pending <= 1'b1;
    end else if (sync_pulse && aligned_valid) begin
      load_pending <= 1'b0;  // Load sync consumed.
    end
  end

  a_single_pulse: assert property (
    @(posedge CLK) disable iff (!arst_n)
    sync_pulse |=> !sync_pulse
  ) else $error("sync_pulse high for two cycles");

endmodule

`default_nettype wire

/* design/lap_align.sv */
`default_nettype none

module lap_align (
  input  wire                   CLK,
  input  wire                   arst_n,
  input  wire sync_pkg::ns_time_t captured_time,
  input  wire                   capture_strobe,
  output sync_pkg::tick_time_t  aligned_time,
  output logic                  aligned_valid
);

  sync_pkg::lap_t       work_q;  // Dividend in, quotient out.
  logic [31:0]          rem_q;
  logic [5:0]           bit_cnt;
  logic                 div_busy;
  logic                 mul_go;

  logic [32:0]          rem_shift;
  logic [32:0]          rem_sub;
  logic                 rem_fits;
  sync_pkg::tick_time_t product;

  assign rem_shift = {rem_q, work_q[63]};
  assign rem_sub   = rem_shift - {1'b0, sync_pkg::SYNC_PERIOD_NS};
  assign rem_fits  = !rem_sub[32];  // No borrow.

  // Shift-add by the constant tick count.
  always_comb begin
    product = '0;
    for (int i = 0; i < $bits(sync_pkg::SYNC_PERIOD_TICKS); i++) begin
      if (sync_pkg::SYNC_PERIOD_TICKS[i]) begin
        product = product + (work_q << i);
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      div_busy      <= 1'b0;
      mul_go        <= 1'b0;
      bit_cnt       <= '0;
      aligned_valid <= 1'b0;
    end else if (capture_strobe) begin
      div_busy      <= 1'b1;  // Restarts any running divide.
      mul_go        <= 1'b0;
      bit_cnt       <= '0;
      aligned_valid <= 1'b0;
    end else if (div_busy) begin
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt == 6'd63) begin
        div_busy <= 1'b0;
        mul_go   <= 1'b1;
      end
    end else if (mul_go) begin
      mul_go        <= 1'b0;
      aligned_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture_strobe) begin
      work_q <= sync_pkg::lap_t'(captured_time);
      rem_q  <= '0;
    end else if (div_busy) begin
      work_q <= {work_q[62:0], rem_fits};
      if (rem_fits) begin
        rem_q <= rem_sub[31:0];
      end else begin
        rem_q <= rem_shift[31:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mul_go) begin
      aligned_time <= product;
    end
  end

  a_strobe_clears_valid: assert property (
    @(posedge CLK) disable iff (!arst_n)
    capture_strobe |=> !aligned_valid
  ) else $error("aligned_valid still high after capture");

endmodule

`default_nettype wire

/* design/sync_predictor.sv */
`default_nettype none

module sync_predictor (
  input  wire                     CLK,
  input  wire                     arst_n,
  input  wire                     sync_pulse,
  input  wire                     load_pending,
  input  wire                     aligned_valid,
  input  wire sync_pkg::tick_time_t aligned_time,
  output sync_pkg::tick_time_t    predicted_time
);

  sync_pkg::period_cnt_t phase_cnt;
  logic                  load_now;
  logic                  phase_end;

  assign load_now  = sync_pulse && load_pending && aligned_valid;
  assign phase_end = (phase_cnt == sync_pkg::SYNC_PERIOD_TICKS - 18'd1);

  // Phase restarts mid-period on every sync.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      phase_cnt <= '0;
    end else if (sync_pulse) begin
      phase_cnt <= sync_pkg::PREDICT_OFFSET;
    end else if (phase_end) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 18'd1;
    end
  end

  // Advancing halfway keeps the value settled well before the next sync.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      predicted_time <= '0;
    end else if (load_now) begin
      predicted_time <= aligned_time;
    end else if (!sync_pulse && phase_end) begin
      predicted_time <= predicted_time +
                        sync_pkg::tick_time_t'(sync_pkg::SYNC_PERIOD_TICKS);
    end
  end

endmodule

`default_nettype wire

/* design/sys_time_core.sv */
`default_nettype none

module sys_time_core (
  input  wire                     CLK,
  input  wire                     arst_n,
  input  wire                     sync_pulse,
  input  wire                     load_pending,
  input  wire                     aligned_valid,
  input  wire sync_pkg::tick_time_t aligned_time,
  input  wire sync_pkg::tick_time_t predicted_time,
  output sync_pkg::tick_time_t    sys_time,
  output logic                    skip
);

  sync_pkg::slew_state_t state;
  sync_pkg::time_diff_t  time_diff;
  sync_pkg::time_diff_t  diff_a;  // Subtractor operands.
  sync_pkg::time_diff_t  diff_b;
  logic                  load_now;
  logic                  diff_pos;
  logic                  diff_neg;

  assign load_now = sync_pulse && load_pending && aligned_valid;
  assign diff_neg = time_diff[64];
  assign diff_pos = !diff_neg && (time_diff != '0);

  always_ff @(posedge CLK) begin
    if (sync_pulse && !load_now) begin
      diff_a <= sync_pkg::time_diff_t'({1'b0, predicted_time});
      diff_b <= sync_pkg::time_diff_t'({1'b0, sys_time + 64'd1});
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= sync_pkg::SLEW_IDLE;
      sys_time  <= '0;
      time_diff <= '0;
      skip      <= 1'b0;
    end else if (load_now) begin
      state     <= sync_pkg::SLEW_IDLE;
      sys_time  <= aligned_time;
      time_diff <= '0;
      skip      <= 1'b0;
    end else if (sync_pulse) begin
      state    <= sync_pkg::SLEW_WAIT_DIFF;  // Drops any slew still running.
      sys_time <= sys_time + 64'd1;
      skip     <= 1'b0;
    end else begin
      case (state)
        sync_pkg::SLEW_WAIT_DIFF: begin
          time_diff <= diff_a - diff_b;
          sys_time  <= sys_time + 64'd1;
          skip      <= 1'b0;
          state     <= sync_pkg::SLEW_ACTIVE;
        end
        sync_pkg::SLEW_ACTIVE: begin
          if (diff_pos) begin
            // Behind the prediction.
            sys_time  <= sys_time + 64'd2;
            time_diff <= time_diff - 65'sd1;
            skip      <= 1'b1;
          end else if (diff_neg) begin
            time_diff <= time_diff + 65'sd1;  // Ahead, so hold.
            skip      <= 1'b0;
          end else begin
            sys_time <= sys_time + 64'd1;
            skip     <= 1'b0;
            state    <= sync_pkg::SLEW_IDLE;
          end
        end
        default: begin
          sys_time <= sys_time + 64'd1;
          skip     <= 1'b0;
          state    <= sync_pkg::SLEW_IDLE;
        end
      endcase
    end
  end

  a_skip_steps_two: assert property (
    @(posedge CLK) disable iff (!arst_n)
    skip |-> (sys_time == $past(sys_time) + 64'd2)
  ) else $error("skip without a double step");

endmodule

`default_nettype wire

/* design/sync_timer_top.sv */
`default_nettype none

module sync_timer_top (
  input  wire                   CLK,
  input  wire                   arst_n,
  input  wire                   ext_sync,
  input  wire sync_pkg::ns_time_t set_time,
  input  wire                   set_update,
  output sync_pkg::tick_time_t  sys_time,
  output logic                  sync,
  output logic                  skip
);

  logic                 sync_pulse;
  sync_pkg::ns_time_t   captured_time;
  logic                 capture_strobe;
  logic                 load_pending;
  sync_pkg::tick_time_t aligned_time;
  logic                 aligned_valid;
  sync_pkg::tick_time_t predicted_time;

  assign sync = sync_pulse;

  sync_input sync_input_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .ext_sync       (ext_sync),
    .set_time       (set_time),
    .set_update     (set_update),
    .aligned_valid  (aligned_valid),
    .sync_pulse     (sync_pulse),
    .captured_time  (captured_time),
    .capture_strobe (capture_strobe),
    .load_pending   (load_pending)
  );

  lap_align lap_align_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .captured_time  (captured_time),
    .capture_strobe (capture_strobe),
    .aligned_time   (aligned_time),
    .aligned_valid  (aligned_valid)
  );

  sync_predictor sync_predictor_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .sync_pulse     (sync_pulse),
    .load_pending   (load_pending),
    .aligned_valid  (aligned_valid),
    .aligned_time   (aligned_time),
    .predicted_time (predicted_time)
  );

  sys_time_core sys_time_core_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .sync_pulse     (sync_pulse),
    .load_pending   (load_pending),
    .aligned_valid  (aligned_valid),
    .aligned_time   (aligned_time),
    .predicted_time (predicted_time),
    .sys_time       (sys_time),
    .skip           (skip)
  );

endmodule

`default_nettype wire

/* verif/tb_sync_timer.sv */
`default_nettype none

module tb_sync_timer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RESET_CYCLES  = 16;
  localparam int          PULSE_TIMEOUT = 16;
  localparam int          VALID_TIMEOUT = 200;
  localparam logic [63:0] TICKS         = 64'd10240;  // Ticks per sync period.

  logic                 CLK;
  logic                 arst_n;
  logic                 ext_sync;
  sync_pkg::ns_time_t   set_time;
  logic                 set_update;
  sync_pkg::tick_time_t sys_time;
  logic                 sync;
  logic                 skip;

  integer               seed;
  sync_pkg::tick_time_t grid_base;  // Aligned value of the latest write.
  int                   loads_requested;

  // Owned by the compare process.
  int                   loads_done = 0;
  int                   pulse_count = 0;
  int                   skip_count = 0;
  int                   hold_count = 0;
  int                   cycles_since_sync = 0;
  int                   gap = 0;
  logic                 check_next = 1'b0;
  sync_pkg::tick_time_t last_grid = '0;
  sync_pkg::tick_time_t last_sample = '0;

  sync_timer_top sync_timer_top_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ext_sync   (ext_sync),
    .set_time   (set_time),
    .set_update (set_update),
    .sys_time   (sys_time),
    .sync       (sync),
    .skip       (skip)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Whole periods in the set time, scaled to ticks.
  function automatic sync_pkg::tick_time_t expected_aligned(input sync_pkg::ns_time_t t_ns);
    logic [63:0] laps;
    laps = t_ns / 64'd500000;
    return laps * 64'd10240;
  endfunction

  function automatic sync_pkg::ns_time_t random_set_time();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed);
    hi = $random(seed);
    return {24'd0, hi[7:0], lo};  // Up to about 1.1e12 ns.
  endfunction

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    stop_on_error();
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic write_set_time(input sync_pkg::ns_time_t t_ns);
    set_time   = t_ns;
    set_update = 1'b1;
    idle(1);
    set_update = 1'b0;
    idle(1);  // Old result is dropped by now.
  endtask

  task automatic wait_aligned();
    int waited;
    waited = 0;
    while (!sync_timer_top_i.aligned_valid && waited < VALID_TIMEOUT) begin
      idle(1);
      waited++;
    end
    if (!sync_timer_top_i.aligned_valid) begin
      fail_run("Aligned time never became valid after a set time write");
    end
  endtask

  task automatic load_new_time();
    sync_pkg::ns_time_t t_ns;
    t_ns = random_set_time();
    write_set_time(t_ns);
    wait_aligned();
    idle(16);
    grid_base = expected_aligned(t_ns);
    loads_requested++;
  endtask

  // One ext_sync rise, then idle until the next rise is due.
  task automatic sync_period(input int cycles);
    int waited;
    waited = 0;
    ext_sync = 1'b1;
    while (!sync && waited < PULSE_TIMEOUT) begin
      idle(1);
      waited++;
    end
    if (!sync) begin
      fail_run("No sync pulse followed the ext_sync edge");
    end
    ext_sync = 1'b0;
    idle(cycles - waited);
  endtask

  // Compares sys_time one cycle after each sync pulse.
  always @(negedge CLK) begin
    sync_pkg::tick_time_t expected;
    if (arst_n) begin
      cycles_since_sync = cycles_since_sync + 1;
      if (skip) begin
        skip_count = skip_count + 1;
      end
      if (sys_time == last_sample) begin
        hold_count = hold_count + 1;
      end
      last_sample = sys_time;
      if (check_next) begin
        check_next  = 1'b0;
        pulse_count = pulse_count + 1;
        if (loads_requested == 0) begin
          fail_run("Sync pulse arrived before any set time was written");
        end
        if (loads_done != loads_requested) begin
          expected   = grid_base;  // Load pulse.
          loads_done = loads_requested;
          last_grid  = grid_base;
        end else begin
          // Previous period was corrected onto the grid.
          expected  = last_grid + 64'(gap);
          last_grid = last_grid + TICKS;
        end
        check_value("sys_time after sync", sys_time, expected);
      end
      if (sync) begin
        gap               = cycles_since_sync;
        cycles_since_sync = 0;
        check_next        = 1'b1;
      end
    end
  end

  initial begin
    sync_pkg::tick_time_t prev;
    int                   skips_before;
    int                   holds_before;
    seed            = 77;
    arst_n          = 1'b0;
    ext_sync        = 1'b0;
    set_time        = '0;
    set_update      = 1'b0;
    grid_base       = '0;
    loads_requested = 0;
    idle(RESET_CYCLES);
    arst_n = 1'b1;

    // Free running from zero.
    check_value("sys_time out of reset", sys_time, 64'd0);
    prev = sys_time;
    repeat (40) begin
      idle(1);
      check_value("sys_time step", sys_time, prev + 64'd1);
      check_value("sync while idle", 64'(sync), 64'd0);
      check_value("skip while idle", 64'(skip), 64'd0);
      prev = sys_time;
    end

    // Load, then regular periods.
    load_new_time();
    skips_before = skip_count;
    holds_before = hold_count;
    repeat (4) begin
      sync_period(10240);
    end
    check_value("skip cycles, regular periods", 64'(skip_count - skips_before), 64'd0);
    check_value("hold cycles, regular periods", 64'(hold_count - holds_before), 64'd0);

    // Early sync leaves the counter 4 behind the prediction.
    sync_period(10236);
    skips_before = skip_count;
    holds_before = hold_count;
    sync_period(10240);
    check_value("skip cycles after short period", 64'(skip_count - skips_before), 64'd4);
    check_value("hold cycles after short period", 64'(hold_count - holds_before), 64'd0);

    // Late sync puts the counter 3 ahead.
    sync_period(10243);
    skips_before = skip_count;
    holds_before = hold_count;
    sync_period(10240);
    check_value("skip cycles after long period", 64'(skip_count - skips_before), 64'd0);
    check_value("hold cycles after long period", 64'(hold_count - holds_before), 64'd3);
    sync_period(10240);

    // Back to back reloads.
    repeat (3) begin
      load_new_time();
      sync_period(10240);
    end
    sync_period(10240);
    idle(4);

    check_value("sync pulses compared", 64'(pulse_count), 64'd13);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/sync_pkg.sv
design/sync_input.sv
design/lap_align.sv
design/sync_predictor.sv
design/sys_time_core.sv
design/sync_timer_top.sv
verif/tb_sync_timer.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_sync_timer -f list.f

status=0
output=$(./obj_dir/Vtb_sync_timer 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
